//--- hw/heapPkg.sv
// ----------------------------------------
// Heap of fixed-size arrays
// Shared widths, types, opcodes and structs
// ----------------------------------------
`default_nettype none

package heapPkg;

  localparam int ArrayBits   = 3;                     // Array id width
  localparam int IndexBits   = 3;                     // Element index width
  localparam int DataBits    = 16;                    // Element width
  localparam int ArrayCount  = 1 << ArrayBits;        // Arrays in the heap
  localparam int ArrayLength = 1 << IndexBits;        // Elements per array

  typedef logic [ArrayBits-1:0] ArrayId;              // Array number
  typedef logic [IndexBits-1:0] ElementIndex;         // Position in array
  typedef logic [IndexBits:0]   ArraySize;            // Count 0 to ArrayLength
  typedef logic [DataBits-1:0]  HeapData;             // Element value, wraps

  typedef enum logic [3:0] {
    opAlloc, opFree, opWrite, opRead, opSize, opPush, opPop,
    opAdd, opAddAfter, opSub, opSubAfter
  } HeapOp;

  typedef enum logic [2:0] {
    errNone, errNotAllocated, errFreed, errOutOfBounds, errFull, errEmpty, errNoArrays
  } HeapError;

  typedef enum logic [1:0] {
    stIdle, stCheck, stExecute, stAck
  } ControlState;

  // ----------------------------------------
  typedef struct packed {
    HeapOp       op;                                  // Operation
    ArrayId      array;                               // Target array
    ElementIndex index;                               // Element in array
    HeapData     data;                                // Operand
  } HeapRequest;

  typedef struct packed {
    HeapData  data;                                   // Result value
    HeapError error;                                  // Fault code
  } HeapResponse;

  typedef struct packed {
    logic        writeElement;                        // Store one element
    ElementIndex writeIndex;                          // Where to store it
    HeapData     writeData;                           // What to store
    logic        writeSize;                           // Replace array size
    ArraySize    newSize;                             // Size to replace with
  } StoreCommand;                                     // Array is the request's

endpackage

`default_nettype wire

//--- hw/heapControl.sv
// ----------------------------------------
// Heap control FSM
// Runs the req/ack handshake, checks faults
// and drives store and allocator commands
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module heapControl (
  input  logic                  clock,
  input  logic                  resetN,
  input  logic                  req,
  input  heapPkg::HeapRequest   request,
  input  logic                  arrayIssued,
  input  logic                  arrayLive,
  input  logic                  canAlloc,
  input  heapPkg::ArrayId       nextArray,
  input  heapPkg::HeapData      element,
  input  heapPkg::ArraySize     size,
  output logic                  ack,
  output logic                  allocCommand,
  output logic                  freeCommand,
  output heapPkg::ElementIndex  readIndex,
  output heapPkg::StoreCommand  storeCommand,
  output heapPkg::HeapResponse  response
);

  heapPkg::ControlState state;                        // Handshake phase
  heapPkg::HeapError    errorReg;                     // Fault found in stCheck
  heapPkg::HeapError    checkError;                   // Fault of current request
  heapPkg::HeapData     newValue;                     // Sum or difference
  heapPkg::HeapData     responseData;                 // Data before error mask
  logic                 indexBeyond;                  // Index at or past size
  logic                 arrayFull;
  logic                 execute;                      // Fault-free execute cycle

  assign indexBeyond = {1'b0, request.index} >= size;
  assign arrayFull   = size == heapPkg::ArraySize'(heapPkg::ArrayLength);
  assign execute     = (state == heapPkg::stExecute) && (errorReg == heapPkg::errNone);
  assign ack         = state == heapPkg::stAck;

  // ----------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      state <= heapPkg::stIdle;
    end else begin
      case (state)
        heapPkg::stIdle:    if (req) state <= heapPkg::stCheck;     // New request
        heapPkg::stCheck:   state <= heapPkg::stExecute;
        heapPkg::stExecute: state <= heapPkg::stAck;                // Response now valid
        heapPkg::stAck:     if (!req) state <= heapPkg::stIdle;     // Host released req
        default:            state <= heapPkg::stIdle;
      endcase
    end
  end

  // Fault checks, all in one place
  always_comb begin
    checkError = heapPkg::errNone;
    if (request.op == heapPkg::opAlloc) begin
      if (!canAlloc) checkError = heapPkg::errNoArrays;             // Every array live
    end else if (!arrayIssued) begin
      checkError = heapPkg::errNotAllocated;                        // Above high water
    end else if (!arrayLive) begin
      checkError = heapPkg::errFreed;
    end else begin
      case (request.op)
        heapPkg::opRead, heapPkg::opAdd, heapPkg::opAddAfter,
        heapPkg::opSub, heapPkg::opSubAfter:
          if (indexBeyond) checkError = heapPkg::errOutOfBounds;
        heapPkg::opPush: if (arrayFull) checkError = heapPkg::errFull;
        heapPkg::opPop:  if (size == '0) checkError = heapPkg::errEmpty;
        default: ;                                                  // Write, size, free
      endcase
    end
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      errorReg  <= heapPkg::errNone;
      readIndex <= '0;
    end else if (state == heapPkg::stCheck) begin
      errorReg  <= checkError;
      readIndex <= (request.op == heapPkg::opPop) ? heapPkg::ElementIndex'(size - 1'b1)
                                                  : request.index;  // Pop reads the top
    end
  end

  // ----------------------------------------
  assign newValue = (request.op == heapPkg::opAdd || request.op == heapPkg::opAddAfter) ?
                    element + request.data : element - request.data;
  assign allocCommand = execute && (request.op == heapPkg::opAlloc);
  assign freeCommand  = execute && (request.op == heapPkg::opFree);

  always_comb begin
    storeCommand            = '0;
    storeCommand.writeIndex = request.index;
    storeCommand.writeData  = newValue;                             // Read-modify-write
    if (execute) begin
      case (request.op)
        heapPkg::opWrite: begin
          storeCommand.writeElement = 1'b1;
          storeCommand.writeData    = request.data;
          storeCommand.writeSize    = indexBeyond;                  // Grow to index plus one
          storeCommand.newSize      = {1'b0, request.index} + 1'b1;
        end
        heapPkg::opPush: begin
          storeCommand.writeElement = 1'b1;
          storeCommand.writeIndex   = heapPkg::ElementIndex'(size); // Append at size
          storeCommand.writeData    = request.data;
          storeCommand.writeSize    = 1'b1;
          storeCommand.newSize      = size + 1'b1;
        end
        heapPkg::opPop: begin
          storeCommand.writeSize = 1'b1;
          storeCommand.newSize   = size - 1'b1;
        end
        // Freed arrays go back empty, so a reused id starts at size zero
        heapPkg::opFree: storeCommand.writeSize = 1'b1;
        heapPkg::opAdd, heapPkg::opAddAfter, heapPkg::opSub, heapPkg::opSubAfter:
          storeCommand.writeElement = 1'b1;
        default: ;
      endcase
    end
  end

  always_comb begin
    case (request.op)
      heapPkg::opAdd, heapPkg::opSub:           responseData = newValue;
      heapPkg::opAddAfter, heapPkg::opSubAfter,
      heapPkg::opRead, heapPkg::opPop:          responseData = element;   // Old value
      heapPkg::opWrite:                         responseData = request.data;
      heapPkg::opSize:                          responseData = heapPkg::HeapData'(size);
      heapPkg::opAlloc:                         responseData = heapPkg::HeapData'(nextArray);
      default:                                  responseData = '0;
    endcase
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      response <= '0;
    end else if (state == heapPkg::stExecute) begin
      response.error <= errorReg;
      response.data  <= (errorReg == heapPkg::errNone) ? responseData : '0;  // Zero on fault
    end
  end

endmodule

`default_nettype wire

//--- hw/arrayAllocator.sv
// ----------------------------------------
// Array id allocator
// Freed-id stack first, then high-water count
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module arrayAllocator (
  input  logic              clock,
  input  logic              resetN,
  input  logic              allocCommand,
  input  logic              freeCommand,
  input  heapPkg::ArrayId   array,
  output logic              arrayIssued,
  output logic              arrayLive,
  output logic              canAlloc,
  output heapPkg::ArrayId   nextArray
);

  logic [heapPkg::ArrayBits:0]      highWater;        // Ids handed out so far
  logic [heapPkg::ArrayBits:0]      freedTop;         // Entries on freed stack
  heapPkg::ArrayId                  freedStack [heapPkg::ArrayCount];
  logic [heapPkg::ArrayCount-1:0]   live;             // One flag per array
  heapPkg::ArrayId                  topSlot;          // Last freed entry
  logic                             stackEmpty;

  assign stackEmpty  = freedTop == '0;
  assign topSlot     = heapPkg::ArrayId'(freedTop - 1'b1);
  assign canAlloc    = !stackEmpty || !highWater[heapPkg::ArrayBits];   // Below ArrayCount
  assign nextArray   = stackEmpty ? heapPkg::ArrayId'(highWater)
                                  : freedStack[topSlot];              // Last freed first
  assign arrayIssued = {1'b0, array} < highWater;
  assign arrayLive   = live[array];

  // ----------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      highWater <= '0;
      freedTop  <= '0;
      live      <= '0;
    end else if (allocCommand) begin
      if (stackEmpty) begin
        highWater <= highWater + 1'b1;                // Fresh id
      end else begin
        freedTop <= freedTop - 1'b1;                  // Reuse freed id
      end
      live[nextArray] <= 1'b1;
    end else if (freeCommand) begin
      freedTop    <= freedTop + 1'b1;
      live[array] <= 1'b0;
    end
  end

  // Stack contents only matter below freedTop
  always_ff @(posedge clock) begin
    if (freeCommand) begin
      freedStack[heapPkg::ArrayId'(freedTop)] <= array;
    end
  end

endmodule

`default_nettype wire

//--- hw/arrayStore.sv
// ----------------------------------------
// Array element memory and size table
// One read and one write per cycle
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module arrayStore (
  input  logic                  clock,
  input  logic                  resetN,
  input  heapPkg::ArrayId       array,
  input  heapPkg::ElementIndex  readIndex,
  input  heapPkg::StoreCommand  storeCommand,
  output heapPkg::HeapData      element,
  output heapPkg::ArraySize     size
);

  // ----------------------------------------
  // Storage
  // ----------------------------------------
  heapPkg::HeapData   elements [heapPkg::ArrayCount][heapPkg::ArrayLength];  // Fixed blocks
  heapPkg::ArraySize  sizes    [heapPkg::ArrayCount];                        // Live length

  // Combinational lookups of registered state
  assign element = elements[array][readIndex];
  assign size    = sizes[array];

  // ----------------------------------------
  // Element write
  // ----------------------------------------
  always_ff @(posedge clock) begin
    if (storeCommand.writeElement) begin
      elements[array][storeCommand.writeIndex] <= storeCommand.writeData;
    end
  end

  // ----------------------------------------
  // Size update
  // ----------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      for (int i = 0; i < heapPkg::ArrayCount; i++) begin
        sizes[i] <= '0;                                   // All arrays empty
      end
    end else if (storeCommand.writeSize) begin
      sizes[array] <= storeCommand.newSize;
    end
  end

endmodule

`default_nettype wire

//--- hw/arrayHeap.sv
// ----------------------------------------
// Array heap top level
// Joins control, allocator and store
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module arrayHeap (
  input  logic                  clock,
  input  logic                  resetN,
  input  logic                  req,
  input  heapPkg::HeapRequest   request,
  output logic                  ack,
  output heapPkg::HeapResponse  response
);

  logic                   allocCommand;               // Allocator pulses
  logic                   freeCommand;
  logic                   arrayIssued;                // Request array status
  logic                   arrayLive;
  logic                   canAlloc;
  heapPkg::ArrayId        nextArray;                  // Id the next alloc returns
  heapPkg::ElementIndex   readIndex;
  heapPkg::StoreCommand   storeCommand;
  heapPkg::HeapData       element;                    // Store lookups
  heapPkg::ArraySize      size;

  heapControl u_heapControl (
    .clock        (clock),
    .resetN       (resetN),
    .req          (req),
    .request      (request),
    .arrayIssued  (arrayIssued),
    .arrayLive    (arrayLive),
    .canAlloc     (canAlloc),
    .nextArray    (nextArray),
    .element      (element),
    .size         (size),
    .ack          (ack),
    .allocCommand (allocCommand),
    .freeCommand  (freeCommand),
    .readIndex    (readIndex),
    .storeCommand (storeCommand),
    .response     (response)
  );

  arrayAllocator u_arrayAllocator (
    .clock        (clock),
    .resetN       (resetN),
    .allocCommand (allocCommand),
    .freeCommand  (freeCommand),
    .array        (request.array),                    // Status of requested array
    .arrayIssued  (arrayIssued),
    .arrayLive    (arrayLive),
    .canAlloc     (canAlloc),
    .nextArray    (nextArray)
  );

  arrayStore u_arrayStore (
    .clock        (clock),
    .resetN       (resetN),
    .array        (request.array),
    .readIndex    (readIndex),
    .storeCommand (storeCommand),
    .element      (element),
    .size         (size)
  );

endmodule

`default_nettype wire

//--- tests/arrayHeapAsserts.sv
// ----------------------------------------
// Handshake assertions for heapControl
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module arrayHeapAsserts (
  input logic                  clock,
  input logic                  resetN,
  input logic                  req,
  input logic                  ack,
  input heapPkg::HeapResponse  response
);

  int failureCount = 0;                               // Failed assertions so far

  ackNeedsReq: assert property (@(posedge clock) disable iff (!resetN)
                                $rose(ack) |-> $past(req))
    else begin
      failureCount++;
      $error("ack rose without req");
    end

  ackHolds: assert property (@(posedge clock) disable iff (!resetN) ack && req |=> ack)
    else begin
      failureCount++;
      $error("ack dropped while req was high");
    end

  responseHolds: assert property (@(posedge clock) disable iff (!resetN)
                                  ack && req |=> $stable(response))
    else begin
      failureCount++;
      $error("response changed while ack was high");
    end

  ackLowInReset: assert property (@(posedge clock) !resetN |-> !ack)
    else begin
      failureCount++;
      $error("ack high during reset");
    end

endmodule

bind heapControl arrayHeapAsserts u_asserts (
  .clock    (clock),
  .resetN   (resetN),
  .req      (req),
  .ack      (ack),
  .response (response)
);

`default_nettype wire

//--- tests/arrayHeapTb.sv
// ----------------------------------------
// Array heap testbench
// Directed and random req/ack traffic
// checked against a reference model
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module arrayHeapTb;

  localparam int ClockPeriod   = 20;
  localparam int ResetCycles   = 16;
  localparam int DirectedCount = 60;                  // Upper bound, directed phase
  localparam int RandomCount   = 400;
  localparam int CycleLimit    = 40;                  // Cycles allowed per transaction

  logic                  clock;
  logic                  resetN;
  logic                  req;
  heapPkg::HeapRequest   request;
  logic                  ack;
  heapPkg::HeapResponse  response;

  // ----------------------------------------
  // Reference model state
  heapPkg::HeapData  modelData  [heapPkg::ArrayCount][heapPkg::ArrayLength];
  logic              modelKnown [heapPkg::ArrayCount][heapPkg::ArrayLength];  // Ever written
  int                modelSize  [heapPkg::ArrayCount];
  logic              modelLive  [heapPkg::ArrayCount];
  int                highWater;                       // Fresh ids handed out
  int                freedIds [$];                    // Last freed at the back
  logic [31:0]       lcgState;
  int                transactionCount;

  arrayHeap u_arrayHeap (
    .clock    (clock),
    .resetN   (resetN),
    .req      (req),
    .request  (request),
    .ack      (ack),
    .response (response)
  );

  always #(ClockPeriod / 2) clock = ~clock;

  function automatic logic [15:0] nextRandom();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState[31:16];                           // Upper bits, better period
  endfunction

  task automatic checkData(string name, heapPkg::HeapData actual, heapPkg::HeapData expected);
    if (actual !== expected) begin
      $display("mismatch %s: got %h expected %h (transaction %0d)",
               name, actual, expected, transactionCount);
      $display("Testbench failed");
      $fatal(1);
    end
  endtask

  task automatic checkError(string name, heapPkg::HeapError actual,
                            heapPkg::HeapError expected);
    if (actual !== expected) begin
      $display("mismatch %s: got %h expected %h (transaction %0d)",
               name, actual, expected, transactionCount);
      $display("Testbench failed");
      $fatal(1);
    end
  endtask

  // Predicts one response and updates the model
  task automatic applyModel(input heapPkg::HeapRequest r, output heapPkg::HeapData data,
                            output heapPkg::HeapError error, output logic dataKnown);
    int a;
    int i;
    heapPkg::HeapData oldValue;
    heapPkg::HeapData newValue;
    a = int'(r.array);
    i = int'(r.index);
    data = '0;
    error = heapPkg::errNone;
    dataKnown = 1'b1;
    if (r.op == heapPkg::opAlloc) begin
      if (freedIds.size() == 0 && highWater == heapPkg::ArrayCount) begin
        error = heapPkg::errNoArrays;                 // All arrays in use
      end else begin
        if (freedIds.size() != 0) begin
          a = freedIds.pop_back();                    // Reuse last freed
        end else begin
          a = highWater;
          highWater++;
        end
        modelLive[a] = 1'b1;
        modelSize[a] = 0;
        data = heapPkg::HeapData'(a);
      end
    end else if (a >= highWater) begin
      error = heapPkg::errNotAllocated;
    end else if (!modelLive[a]) begin
      error = heapPkg::errFreed;
    end else begin
      case (r.op)
        heapPkg::opFree: begin
          modelLive[a] = 1'b0;
          freedIds.push_back(a);
        end
        heapPkg::opWrite: begin
          modelData[a][i] = r.data;
          modelKnown[a][i] = 1'b1;
          if (i >= modelSize[a]) modelSize[a] = i + 1;   // Grows to index plus one
          data = r.data;
        end
        heapPkg::opSize: data = heapPkg::HeapData'(modelSize[a]);
        heapPkg::opPush: begin
          if (modelSize[a] == heapPkg::ArrayLength) begin
            error = heapPkg::errFull;
          end else begin
            modelData[a][modelSize[a]] = r.data;
            modelKnown[a][modelSize[a]] = 1'b1;
            modelSize[a]++;
          end
        end
        heapPkg::opPop: begin
          if (modelSize[a] == 0) begin
            error = heapPkg::errEmpty;
          end else begin
            modelSize[a]--;
            data = modelData[a][modelSize[a]];        // Top element
            dataKnown = modelKnown[a][modelSize[a]];
          end
        end
        default: begin                                // Read and element arithmetic
          if (i >= modelSize[a]) begin
            error = heapPkg::errOutOfBounds;
          end else begin
            oldValue = modelData[a][i];
            dataKnown = modelKnown[a][i];
            if (r.op == heapPkg::opAdd || r.op == heapPkg::opAddAfter) begin
              newValue = oldValue + r.data;           // Wraps at 16 bits
            end else begin
              newValue = oldValue - r.data;
            end
            if (r.op == heapPkg::opRead) begin
              data = oldValue;
            end else begin
              modelData[a][i] = newValue;
              data = (r.op == heapPkg::opAdd || r.op == heapPkg::opSub) ? newValue : oldValue;
            end
          end
        end
      endcase
    end
    if (error != heapPkg::errNone) data = '0;
  endtask

  // One four-phase transaction, entered and left on a falling edge with ack low
  task automatic runTransaction(heapPkg::HeapOp op, int array, int index, int data);
    heapPkg::HeapRequest r;
    heapPkg::HeapData    expectData;
    heapPkg::HeapError   expectError;
    logic                dataKnown;
    int                  holdCycles;
    r.op    = op;
    r.array = heapPkg::ArrayId'(array);
    r.index = heapPkg::ElementIndex'(index);
    r.data  = heapPkg::HeapData'(data);
    holdCycles = transactionCount % 3;                // Back-pressure of 0 to 2 cycles
    applyModel(r, expectData, expectError, dataKnown);
    request = r;
    req = 1'b1;
    do @(negedge clock); while (!ack);
    checkError("response.error", response.error, expectError);
    if (dataKnown) checkData("response.data", response.data, expectData);
    repeat (holdCycles) @(negedge clock);             // req held past ack
    checkError("response.error", response.error, expectError);
    if (dataKnown) checkData("response.data", response.data, expectData);
    req = 1'b0;
    do @(negedge clock); while (ack);
    transactionCount++;
  endtask

  // ----------------------------------------
  initial begin
    clock = 1'b0;
    resetN = 1'b0;
    req = 1'b0;
    request = '0;
    lcgState = 32'h1d7f;
    highWater = 0;
    transactionCount = 0;
    for (int a = 0; a < heapPkg::ArrayCount; a++) begin
      modelSize[a] = 0;
      modelLive[a] = 1'b0;
      for (int i = 0; i < heapPkg::ArrayLength; i++) modelKnown[a][i] = 1'b0;
    end
    repeat (ResetCycles) @(negedge clock);
    resetN = 1'b1;

    runTransaction(heapPkg::opRead, 0, 0, 0);          // Nothing issued yet
    for (int k = 0; k < 9; k++) runTransaction(heapPkg::opAlloc, 0, 0, 0);
    runTransaction(heapPkg::opWrite, 0, 2, 16'h1234);
    runTransaction(heapPkg::opRead, 0, 2, 0);
    runTransaction(heapPkg::opSize, 0, 0, 0);
    runTransaction(heapPkg::opRead, 0, 3, 0);          // Beyond size
    runTransaction(heapPkg::opWrite, 0, 0, 16'hbeef);
    runTransaction(heapPkg::opRead, 0, 0, 0);
    for (int k = 0; k < 9; k++) runTransaction(heapPkg::opPush, 1, 0, k * 111 + 5);
    for (int k = 0; k < 9; k++) runTransaction(heapPkg::opPop, 1, 0, 0);
    runTransaction(heapPkg::opFree, 3, 0, 0);
    runTransaction(heapPkg::opFree, 5, 0, 0);
    runTransaction(heapPkg::opRead, 3, 0, 0);
    runTransaction(heapPkg::opFree, 3, 0, 0);          // Second free of same id
    runTransaction(heapPkg::opAlloc, 0, 0, 0);
    runTransaction(heapPkg::opAlloc, 0, 0, 0);
    runTransaction(heapPkg::opWrite, 2, 0, 16'hfffe);
    runTransaction(heapPkg::opAdd, 2, 0, 5);
    runTransaction(heapPkg::opAddAfter, 2, 0, 1);
    runTransaction(heapPkg::opSub, 2, 0, 16'h0010);
    runTransaction(heapPkg::opSubAfter, 2, 0, 3);
    runTransaction(heapPkg::opRead, 2, 0, 0);

    for (int k = 0; k < RandomCount; k++) begin
      runTransaction(heapPkg::HeapOp'(nextRandom() % 11), int'(nextRandom() % 8),
                     int'(nextRandom() % 8), int'(nextRandom()));
    end

    if (u_arrayHeap.u_heapControl.u_asserts.failureCount != 0) begin
      $display("Handshake assertions failed %0d times",
               u_arrayHeap.u_heapControl.u_asserts.failureCount);
      $display("Testbench failed");
      $fatal(1);
    end else begin
      $display("Testbench passed");
      $finish;
    end
  end

  // Watchdog sized from the transaction count
  initial begin
    #((ResetCycles + (DirectedCount + RandomCount) * CycleLimit) * ClockPeriod);
    $display("Timeout, the DUT stopped answering after %0d transactions", transactionCount);
    $display("Testbench failed");
    $fatal(1);
  end

endmodule

`default_nettype wire

//--- filelist.f
hw/heapPkg.sv
hw/heapControl.sv
hw/arrayAllocator.sv
hw/arrayStore.sv
hw/arrayHeap.sv
tests/arrayHeapAsserts.sv
tests/arrayHeapTb.sv

//--- Makefile
SIM = obj_dir/arrayHeapSim

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module arrayHeap -f filelist.f

sim:
	verilator --binary --timing --assert --top-module arrayHeapTb -f filelist.f -o arrayHeapSim
	./$(SIM) +verilator+error+limit+100 | tee /dev/stderr | grep -q "Testbench passed"

clean:
	rm -rf obj_dir
